//--- verilog/rhBusPkg.sv
// Device bus widths and the bus write cycle request struct
`default_nettype none

package rhBusPkg;

   //////////////////////////////////////////////////
   // Device bus dimensions
   //////////////////////////////////////////////////

   // Full device data path, numbered big-endian on the bus
   localparam int devDataWidth = 36;

   // Register offset within the controller window
   localparam int devOffWidth = 6;

   //////////////////////////////////////////////////
   // One device bus cycle
   //////////////////////////////////////////////////

   // Write request as presented to the register block
   // Data keeps the bus bit order, bit 0 is the MSB
   typedef struct packed {
      // Write strobe
      logic wr;
      // Device reset from the bus
      logic devReset;
      // Byte lane enables
      logic loByte;
      logic hiByte;
      // Register offset
      logic [devOffWidth-1:0] offset;
      // Write data, big-endian
      logic [0:devDataWidth-1] data;
   } devReq;

endpackage

`default_nettype wire

//--- verilog/rhRegPkg.sv
// Register offsets, CS1 field positions, function codes, register widths and strobes
`default_nettype none

package rhRegPkg;

   //////////////////////////////////////////////////
   // Register widths
   //////////////////////////////////////////////////

   // Visible register width on the 18-bit side
   localparam int regDataWidth = 18;

   // Default bus address width
   localparam int baWidth = 18;

   //////////////////////////////////////////////////
   // Register offsets
   //////////////////////////////////////////////////

   localparam logic [5:0] cs1Addr = 6'd0;
   localparam logic [5:0] wcAddr  = 6'd2;
   localparam logic [5:0] baAddr  = 6'd4;

   //////////////////////////////////////////////////
   // CS1 field positions
   //////////////////////////////////////////////////

   localparam int cs1Go     = 0;
   localparam int cs1FunLsb = 1;
   localparam int cs1FunMsb = 5;
   localparam int cs1Ie     = 6;
   localparam int cs1Rdy    = 7;
   // Extended address bits, written through the high byte
   localparam int cs1BaeLsb = 8;
   localparam int cs1BaeMsb = 9;
   // Controller clear, bit 5 of the high byte
   localparam int cs1Clr    = 13;

   localparam int funWidth = cs1FunMsb - cs1FunLsb + 1;
   localparam int baeWidth = cs1BaeMsb - cs1BaeLsb + 1;

   // Data transfer functions, top bit set marks any transfer
   localparam logic [funWidth-1:0] funReadData  = 5'b11100;
   localparam logic [funWidth-1:0] funWriteData = 5'b11000;

   // Per-register write strobes with lanes and little-endian data
   typedef struct packed {
      logic cs1Wr;
      logic wcWr;
      logic baWr;
      logic loByte;
      logic hiByte;
      logic [regDataWidth-1:0] data;
   } regStrobes;

endpackage

`default_nettype wire

//--- verilog/rhRegDecode.sv
// Bus lane swap, register write strobe decode, controller clear and read data mux
`default_nettype none
`timescale 1ns/1ps

module rhRegDecode import rhBusPkg::*, rhRegPkg::*;
#(
   parameter int addrWidth = baWidth
)
(
   input  devReq                   bus,
   input  logic [regDataWidth-1:0] cs1Value,
   input  logic [regDataWidth-1:0] wcValue,
   input  logic [addrWidth-1:0]    baValue,
   output regStrobes               strobes,
   output logic                    ctrlClear,
   output logic [regDataWidth-1:0] readData
);

   // Little-endian view of the bus data
   logic [devDataWidth-1:0] busData;
   logic cs1Sel;
   logic wcSel;
   logic baSel;

   //////////////////////////////////////////////////
   // Write side
   //////////////////////////////////////////////////

   // Big-endian bus bit 0 lands on bit 35
   assign busData = bus.data;

   // Offset match
   assign cs1Sel = (bus.offset == cs1Addr);
   assign wcSel  = (bus.offset == wcAddr);
   assign baSel  = (bus.offset == baAddr);

   // One strobe per register, only on a write cycle
   assign strobes.cs1Wr  = bus.wr & cs1Sel;
   assign strobes.wcWr   = bus.wr & wcSel;
   assign strobes.baWr   = bus.wr & baSel;
   assign strobes.loByte = bus.loByte;
   assign strobes.hiByte = bus.hiByte;
   // Registers only see the low 18 bits
   assign strobes.data   = busData[regDataWidth-1:0];

   // Controller clear from device reset or the CS1 clear bit
   assign ctrlClear = bus.devReset |
                      (strobes.cs1Wr & bus.hiByte & busData[cs1Clr]);

   //////////////////////////////////////////////////
   // Read side
   //////////////////////////////////////////////////

   // Zero latency mux, unknown offsets read as zero
   always_comb
   begin
      case (bus.offset)
         cs1Addr:
            readData = cs1Value;
         wcAddr:
            readData = wcValue;
         baAddr:
            readData = regDataWidth'(baValue);
         default:
            readData = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/rhCs1.sv
// Control/status register 1 with function, GO pulse, ready, interrupt enable and BAE bits
`default_nettype none
`timescale 1ns/1ps

module rhCs1 import rhRegPkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  regStrobes               strobes,
   input  logic                    ctrlClear,
   input  logic                    setReady,
   input  logic                    clearReady,
   output logic [regDataWidth-1:0] cs1Value,
   output logic [funWidth-1:0]     funCode,
   output logic                    goPulse,
   output logic                    baeLoad,
   output logic [baeWidth-1:0]     baeBits,
   output logic                    ready
);

   // Stored fields
   logic [funWidth-1:0] fun;
   logic ie;
   logic [baeWidth-1:0] bae;
   logic rdy;

   // Low byte carries GO, function and IE
   logic loWrite;
   logic goWrite;

   assign loWrite = strobes.cs1Wr & strobes.loByte;
   // GO is ignored while a command is running
   assign goWrite = loWrite & strobes.data[cs1Go] & rdy;

   // High byte write while ready also feeds BA
   assign baeLoad = strobes.cs1Wr & strobes.hiByte & rdy;
   assign baeBits = strobes.data[cs1BaeMsb:cs1BaeLsb];

   //////////////////////////////////////////////////
   // Register fields
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fun     <= '0;
         ie      <= 1'b0;
         bae     <= '0;
         rdy     <= 1'b1;
         goPulse <= 1'b0;
      end
      else if (ctrlClear)
      begin
         // Clear wins over any write in the same cycle
         fun     <= '0;
         ie      <= 1'b0;
         bae     <= '0;
         rdy     <= 1'b1;
         goPulse <= 1'b0;
      end
      else
      begin
         if (loWrite)
         begin
            fun <= strobes.data[cs1FunMsb:cs1FunLsb];
            ie  <= strobes.data[cs1Ie];
         end
         if (baeLoad)
            bae <= baeBits;
         // Sequencer drives ready after the first edge
         if (clearReady)
            rdy <= 1'b0;
         else if (setReady)
            rdy <= 1'b1;
         // Single cycle pulse, new function already visible
         goPulse <= goWrite;
      end
   end

   assign funCode = fun;
   assign ready   = rdy;

   // GO reads back as zero
   assign cs1Value = regDataWidth'({bae, rdy, ie, fun, 1'b0});

endmodule

`default_nettype wire

//--- verilog/rhBa.sv
// Bus address register with clears, byte writes, BAE load and inhibitable increment
`default_nettype none
`timescale 1ns/1ps

module rhBa import rhRegPkg::*;
#(
   parameter int addrWidth = baWidth
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  regStrobes            strobes,
   input  logic                 ctrlClear,
   input  logic                 baeLoad,
   input  logic [baeWidth-1:0]  baeBits,
   input  logic                 stepPulse,
   input  logic                 incInhibit,
   output logic [addrWidth-1:0] baValue
);

   // Word address, bit zero is not stored
   logic [addrWidth-1:1] addr;

   //////////////////////////////////////////////////
   // Address register
   //////////////////////////////////////////////////

   // Priority: clear, BAE load, byte write, step
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         addr <= '0;
      else if (ctrlClear)
         addr <= '0;
      else if (baeLoad)
         // Top bits come from the CS1 high byte
         addr[addrWidth-1 -: baeWidth] <= baeBits;
      else if (strobes.baWr)
      begin
         if (strobes.hiByte)
            addr[15:8] <= strobes.data[15:8];
         if (strobes.loByte)
            addr[7:1] <= strobes.data[7:1];
      end
      else if (stepPulse & ~incInhibit)
         // One word forward, wraps at the top
         addr <= addr + 1'b1;
   end

   // Addresses are always even
   assign baValue = {addr, 1'b0};

endmodule

`default_nettype wire

//--- verilog/rhWc.sv
// Word count register counting up to zero, with byte writes and a registered zero flag
`default_nettype none
`timescale 1ns/1ps

module rhWc import rhRegPkg::*;
#(
   parameter int wcWidth = 16
)
(
   input  logic               clk,
   input  logic               rst,
   input  regStrobes          strobes,
   input  logic               ctrlClear,
   input  logic               stepPulse,
   output logic [wcWidth-1:0] wcValue,
   output logic               wcZero
);

   // Negative count, two's complement
   logic [wcWidth-1:0] count;
   logic [wcWidth-1:0] countNext;

   //////////////////////////////////////////////////
   // Next count
   //////////////////////////////////////////////////

   // Clear first, then byte writes, then steps
   always_comb
   begin
      countNext = count;
      if (ctrlClear)
         countNext = '0;
      else if (strobes.wcWr)
      begin
         if (strobes.hiByte)
            countNext[wcWidth-1:8] = strobes.data[wcWidth-1:8];
         if (strobes.loByte)
            countNext[7:0] = strobes.data[7:0];
      end
      else if (stepPulse)
         countNext = count + 1'b1;
   end

   // Zero flag registered together with the count
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count  <= '0;
         wcZero <= 1'b1;
      end
      else
      begin
         count  <= countNext;
         wcZero <= (countNext == '0);
      end
   end

   assign wcValue = count;

endmodule

`default_nettype wire

//--- verilog/rhXferSeq.sv
// Transfer sequencer FSM issuing address and count steps and ending the transfer
`default_nettype none
`timescale 1ns/1ps

module rhXferSeq import rhRegPkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                goPulse,
   input  logic [funWidth-1:0] funCode,
   input  logic                wordStrobe,
   input  logic                wcZero,
   input  logic                ctrlClear,
   output logic                stepPulse,
   output logic                setReady,
   output logic                clearReady,
   output logic                xferActive
);

   // Finishing means a step just landed and the count is under test
   typedef enum logic [1:0] {idle, running, finishing} seqState;

   seqState state;
   seqState stateNext;
   logic stepReg;
   logic xferGo;
   logic endNow;

   // Any function with the top bit set is a data transfer
   assign xferGo = goPulse & funCode[funWidth-1];

   // Count reached zero on the step that just landed
   assign endNow = (state == finishing) & wcZero;

   assign clearReady = (state == idle) & xferGo;
   assign setReady   = endNow;
   // Words past the end of the count are dropped
   assign stepPulse  = stepReg & ~endNow;
   assign xferActive = (state != idle);

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////

   always_comb
   begin
      stateNext = state;
      case (state)
         idle:
            if (xferGo)
               stateNext = running;
         running:
            if (stepPulse)
               stateNext = finishing;
         finishing:
            if (wcZero)
               stateNext = idle;
            else if (!stepPulse)
               stateNext = running;
         default:
            stateNext = idle;
      endcase
   end

   // Clear aborts to idle, stray strobes ignored outside a transfer
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= idle;
         stepReg <= 1'b0;
      end
      else if (ctrlClear)
      begin
         state   <= idle;
         stepReg <= 1'b0;
      end
      else
      begin
         state   <= stateNext;
         stepReg <= wordStrobe & (state != idle) & ~endNow;
      end
   end

endmodule

`default_nettype wire

//--- verilog/rh11Regs.sv
// Top level of the RH11 register block, decoder, CS1, WC, BA and transfer sequencer
`default_nettype none
`timescale 1ns/1ps

module rh11Regs import rhBusPkg::*, rhRegPkg::*;
#(
   parameter int addrWidth = baWidth,
   parameter int wcWidth   = 16
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  devReq                   bus,
   input  logic                    wordStrobe,
   input  logic                    incInhibit,
   output logic [regDataWidth-1:0] readData,
   output logic [addrWidth-1:0]    busAddr,
   output logic                    ready,
   output logic                    xferActive
);

   regStrobes strobes;
   logic ctrlClear;
   logic [regDataWidth-1:0] cs1Value;
   logic [wcWidth-1:0] wcValue;
   logic [funWidth-1:0] funCode;
   logic goPulse;
   logic baeLoad;
   logic [baeWidth-1:0] baeBits;
   logic stepPulse;
   logic setReady;
   logic clearReady;
   logic wcZero;

   //////////////////////////////////////////////////
   // Bus side
   //////////////////////////////////////////////////

   rhRegDecode #(.addrWidth(addrWidth)) regDecode (
      .bus(bus),
      .cs1Value(cs1Value),
      .wcValue(regDataWidth'(wcValue)),
      .baValue(busAddr),
      .strobes(strobes),
      .ctrlClear(ctrlClear),
      .readData(readData)
   );

   // Registers
   rhCs1 cs1 (
      .clk(clk),
      .rst(rst),
      .strobes(strobes),
      .ctrlClear(ctrlClear),
      .setReady(setReady),
      .clearReady(clearReady),
      .cs1Value(cs1Value),
      .funCode(funCode),
      .goPulse(goPulse),
      .baeLoad(baeLoad),
      .baeBits(baeBits),
      .ready(ready)
   );

   rhBa #(.addrWidth(addrWidth)) ba (
      .clk(clk),
      .rst(rst),
      .strobes(strobes),
      .ctrlClear(ctrlClear),
      .baeLoad(baeLoad),
      .baeBits(baeBits),
      .stepPulse(stepPulse),
      .incInhibit(incInhibit),
      .baValue(busAddr)
   );

   rhWc #(.wcWidth(wcWidth)) wc (
      .clk(clk),
      .rst(rst),
      .strobes(strobes),
      .ctrlClear(ctrlClear),
      .stepPulse(stepPulse),
      .wcValue(wcValue),
      .wcZero(wcZero)
   );

   // Drive side stepping
   rhXferSeq xferSeq (
      .clk(clk),
      .rst(rst),
      .goPulse(goPulse),
      .funCode(funCode),
      .wordStrobe(wordStrobe),
      .wcZero(wcZero),
      .ctrlClear(ctrlClear),
      .stepPulse(stepPulse),
      .setReady(setReady),
      .clearReady(clearReady),
      .xferActive(xferActive)
   );

endmodule

`default_nettype wire

//--- testbench/rh11Regs_properties.sv
// Bound concurrent assertions on clears, increment inhibit, GO timing and transfer end
`default_nettype none
`timescale 1ns/1ps

module rh11RegsProperties import rhRegPkg::*;
#(
   parameter int addrWidth = baWidth,
   parameter int wcWidth   = 16
)
(
   input logic                 clk,
   input logic                 rst,
   input regStrobes            strobes,
   input logic                 ctrlClear,
   input logic                 goPulse,
   input logic [funWidth-1:0]  funCode,
   input logic                 stepPulse,
   input logic                 incInhibit,
   input logic                 baeLoad,
   input logic [addrWidth-1:0] busAddr,
   input logic [wcWidth-1:0]   wcValue,
   input logic                 ready,
   input logic                 xferActive
);

   // Failure count for the testbench summary
   int propErrors = 0;

   //////////////////////////////////////////////////
   // Clears
   //////////////////////////////////////////////////

   // Everything zero and ready one cycle after a clear
   clearZeroes: assert property (@(posedge clk) disable iff (rst)
      ctrlClear |=> (busAddr == '0) && (wcValue == '0) && ready && !xferActive)
   else
   begin
      propErrors++;
      $error("Clear did not zero the registers and return ready");
   end

   //////////////////////////////////////////////////
   // Stepping
   //////////////////////////////////////////////////

   // Inhibited step holds the address
   inhibitHolds: assert property (@(posedge clk) disable iff (rst)
      stepPulse && incInhibit && !ctrlClear && !baeLoad && !strobes.baWr
      |=> $stable(busAddr))
   else
   begin
      propErrors++;
      $error("Address moved on an inhibited step");
   end

   // Count always advances by one per step
   countSteps: assert property (@(posedge clk) disable iff (rst)
      stepPulse && !ctrlClear && !strobes.wcWr
      |=> wcValue == wcWidth'($past(wcValue) + 1'b1))
   else
   begin
      propErrors++;
      $error("Word count did not advance on a step");
   end

   // No steps outside a transfer
   noStrayStep: assert property (@(posedge clk) disable iff (rst)
      !xferActive |-> !stepPulse)
   else
   begin
      propErrors++;
      $error("Step issued while idle");
   end

   //////////////////////////////////////////////////
   // GO and transfer end
   //////////////////////////////////////////////////

   // Transfer GO drops ready next cycle
   goBusy: assert property (@(posedge clk) disable iff (rst)
      goPulse && funCode[funWidth-1] && !ctrlClear |=> !ready && xferActive)
   else
   begin
      propErrors++;
      $error("Transfer GO did not start a transfer");
   end

   // Non-transfer GO keeps ready
   goNoXfer: assert property (@(posedge clk) disable iff (rst)
      goPulse && !funCode[funWidth-1] && !ctrlClear |=> ready && !xferActive)
   else
   begin
      propErrors++;
      $error("Non-transfer GO dropped ready");
   end

   // Step landing the count on zero ends the transfer one cycle later
   endXfer: assert property (@(posedge clk) disable iff (rst)
      stepPulse && !ctrlClear && !strobes.wcWr ##1 (wcValue == '0)
      |=> ready && !xferActive)
   else
   begin
      propErrors++;
      $error("Transfer end did not return ready");
   end

endmodule

`default_nettype wire

//--- testbench/rh11RegsTb.sv
// Testbench for the RH11 register block, stimulus, register model, read-back checks, timeout
`default_nettype none
`timescale 1ns/1ps

module rh11RegsTb import rhBusPkg::*, rhRegPkg::*;
();

   localparam int addrWidth = 18;
   localparam int wcWidth = 16;
   // Well above the cycles all tests take
   localparam int timeoutCycles = 4000;

   logic clk;
   logic rst;
   devReq bus;
   logic wordStrobe;
   logic incInhibit;
   logic [regDataWidth-1:0] readData;
   logic [addrWidth-1:0] busAddr;
   logic ready;
   logic xferActive;

   // Register model
   logic [addrWidth-1:0] baModel;
   logic [wcWidth-1:0] wcModel;
   logic [baeWidth-1:0] baeModel;
   logic [funWidth-1:0] funModel;
   logic ieModel;
   logic rdyModel;

   logic [31:0] seed;
   int errors;
   int cycles;

   rh11Regs #(.addrWidth(addrWidth), .wcWidth(wcWidth)) UUT (
      .clk(clk),
      .rst(rst),
      .bus(bus),
      .wordStrobe(wordStrobe),
      .incInhibit(incInhibit),
      .readData(readData),
      .busAddr(busAddr),
      .ready(ready),
      .xferActive(xferActive)
   );

   bind rh11Regs rh11RegsProperties #(.addrWidth(addrWidth), .wcWidth(wcWidth)) props (
      .clk(clk),
      .rst(rst),
      .strobes(strobes),
      .ctrlClear(ctrlClear),
      .goPulse(goPulse),
      .funCode(funCode),
      .stepPulse(stepPulse),
      .incInhibit(incInhibit),
      .baeLoad(baeLoad),
      .busAddr(busAddr),
      .wcValue(wcValue),
      .ready(ready),
      .xferActive(xferActive)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // CS1 as the model expects to read it with GO at zero
   function automatic logic [regDataWidth-1:0] cs1Expected();
      logic [regDataWidth-1:0] v;
      v = '0;
      v[cs1BaeMsb:cs1BaeLsb] = baeModel;
      v[cs1Rdy] = rdyModel;
      v[cs1Ie] = ieModel;
      v[cs1FunMsb:cs1FunLsb] = funModel;
      return v;
   endfunction

   task automatic checkValue(input string what, input logic [regDataWidth-1:0] got,
                             input logic [regDataWidth-1:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkFlag(input string what, input logic got, input logic exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // One bus cycle sampled on the second edge
   task automatic busCycle(input devReq req);
      @(posedge clk);
      bus <= req;
      @(posedge clk);
      bus <= '0;
   endtask

   task automatic regWrite(input logic [5:0] offset, input logic [regDataWidth-1:0] data,
                           input logic lo, input logic hi);
      devReq req;
      req = '0;
      req.wr = 1'b1;
      req.loByte = lo;
      req.hiByte = hi;
      req.offset = offset;
      req.data = devDataWidth'(data);
      busCycle(req);
   endtask

   task automatic clearModel();
      baModel = '0;
      wcModel = '0;
      baeModel = '0;
      funModel = '0;
      ieModel = 1'b0;
      rdyModel = 1'b1;
   endtask

   task automatic writeBa(input logic [regDataWidth-1:0] data, input logic lo, input logic hi);
      if (hi)
         baModel[15:8] = data[15:8];
      if (lo)
         baModel[7:1] = data[7:1];
      regWrite(baAddr, data, lo, hi);
   endtask

   task automatic writeWc(input logic [regDataWidth-1:0] data, input logic lo, input logic hi);
      if (hi)
         wcModel[15:8] = data[15:8];
      if (lo)
         wcModel[7:0] = data[7:0];
      regWrite(wcAddr, data, lo, hi);
   endtask

   // Clear bit, then extended bits on the old ready, then GO
   task automatic writeCs1(input logic [regDataWidth-1:0] data, input logic lo, input logic hi);
      if (hi && data[cs1Clr])
         clearModel();
      else
      begin
         if (hi && rdyModel)
         begin
            baeModel = data[cs1BaeMsb:cs1BaeLsb];
            baModel[addrWidth-1 -: baeWidth] = data[cs1BaeMsb:cs1BaeLsb];
         end
         if (lo)
         begin
            funModel = data[cs1FunMsb:cs1FunLsb];
            ieModel = data[cs1Ie];
            if (data[cs1Go] && rdyModel && data[cs1FunMsb])
               rdyModel = 1'b0;
         end
      end
      regWrite(cs1Addr, data, lo, hi);
   endtask

   task automatic readCheck(input logic [5:0] offset, input logic [regDataWidth-1:0] exp,
                            input string what);
      devReq req;
      req = '0;
      req.offset = offset;
      @(posedge clk);
      bus <= req;
      @(negedge clk);
      checkValue(what, readData, exp);
   endtask

   // Read back all three registers and the status outputs
   task automatic checkAll();
      readCheck(cs1Addr, cs1Expected(), "CS1");
      readCheck(wcAddr, regDataWidth'(wcModel), "WC");
      readCheck(baAddr, baModel, "BA");
      checkValue("busAddr", busAddr, baModel);
      checkFlag("ready", ready, rdyModel);
      checkFlag("xferActive", xferActive, ~rdyModel);
   endtask

   task automatic pulseStrobes(input int n, input int gap);
      repeat (n)
      begin
         @(posedge clk);
         wordStrobe <= 1'b1;
         repeat (gap)
         begin
            @(posedge clk);
            wordStrobe <= 1'b0;
         end
      end
      @(posedge clk);
      wordStrobe <= 1'b0;
   endtask

   task automatic startXfer(input int n, input logic [funWidth-1:0] fun);
      logic [wcWidth-1:0] negCount;
      negCount = wcWidth'(-n);
      writeWc(regDataWidth'(negCount), 1'b1, 1'b1);
      writeCs1(regDataWidth'({fun, 1'b1}), 1'b1, 1'b0);
      @(negedge clk);
      while (!xferActive)
         @(negedge clk);
   endtask

   // Full transfer of n words with surplus strobes at the end
   task automatic runTransfer(input int n, input logic inhibit,
                              input logic [funWidth-1:0] fun);
      logic [regDataWidth-1:0] baeData;
      @(posedge clk);
      incInhibit <= inhibit;
      startXfer(n, fun);
      // Extended bits are locked while busy
      baeData = '0;
      baeData[cs1BaeMsb:cs1BaeLsb] = ~baeModel;
      writeCs1(baeData, 1'b0, 1'b1);
      checkAll();
      pulseStrobes(n + 2, 0);
      @(negedge clk);
      while (!ready)
         @(negedge clk);
      if (!inhibit)
         baModel = baModel + addrWidth'(2 * n);
      wcModel = '0;
      rdyModel = 1'b1;
      @(posedge clk);
      incInhibit <= 1'b0;
      checkAll();
   endtask

   // Three steps into a transfer, then a clear
   task automatic midClear(input logic useDevReset);
      devReq req;
      writeBa(18'h0abc6, 1'b1, 1'b1);
      startXfer(10, funReadData);
      pulseStrobes(3, 0);
      repeat (3) @(posedge clk);
      baModel = baModel + addrWidth'(6);
      wcModel = wcModel + wcWidth'(3);
      checkAll();
      if (useDevReset)
      begin
         req = '0;
         req.devReset = 1'b1;
         clearModel();
         busCycle(req);
      end
      else
         writeCs1(regDataWidth'(1) << cs1Clr, 1'b0, 1'b1);
      checkAll();
   endtask

   //////////////////////////////////////////////////
   // Timeout
   //////////////////////////////////////////////////

   initial
   begin
      cycles = 0;
      while (cycles < timeoutCycles)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d clock cycles", timeoutCycles);
      $display("Something failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      rst = 1'b1;
      bus = '0;
      wordStrobe = 1'b0;
      incInhibit = 1'b0;
      errors = 0;
      seed = 32'h3224;
      clearModel();
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      checkAll();

      // Byte lanes in every enable combination
      for (int round = 0; round < 4; round++)
      begin
         for (int lanes = 0; lanes < 4; lanes++)
         begin
            seed = lcgNext(seed);
            writeBa(seed[25:8], lanes[0], lanes[1]);
            seed = lcgNext(seed);
            writeWc(seed[25:8], lanes[0], lanes[1]);
            checkAll();
         end
      end

      // Extended bits while ready
      writeCs1(regDataWidth'(2'b10) << cs1BaeLsb, 1'b0, 1'b1);
      checkAll();

      // Transfers of random length
      seed = lcgNext(seed);
      runTransfer(1 + int'(seed[19:16]), 1'b0, funReadData);
      seed = lcgNext(seed);
      runTransfer(1 + int'(seed[19:16]), 1'b0, funReadData);

      // GO with a non-transfer function and IE set
      writeCs1(regDataWidth'({1'b1, 5'b00011, 1'b1}), 1'b1, 1'b0);
      repeat (3) @(posedge clk);
      checkAll();

      // Inhibited transfer
      seed = lcgNext(seed);
      runTransfer(1 + int'(seed[19:16]), 1'b1, funWriteData);

      // Stray strobes while idle
      seed = lcgNext(seed);
      writeWc(seed[25:8], 1'b1, 1'b1);
      pulseStrobes(5, 2);
      repeat (3) @(posedge clk);
      checkAll();

      midClear(1'b1);
      midClear(1'b0);

      repeat (4) @(posedge clk);
      $display("Check errors: %0d, property failures: %0d", errors, UUT.props.propErrors);
      if (errors == 0 && UUT.props.propErrors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- rh11Regs.f
verilog/rhBusPkg.sv
verilog/rhRegPkg.sv
verilog/rhRegDecode.sv
verilog/rhCs1.sv
verilog/rhBa.sv
verilog/rhWc.sv
verilog/rhXferSeq.sv
verilog/rh11Regs.sv
testbench/rh11Regs_properties.sv
testbench/rh11RegsTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rh11RegsTb
FILELIST = rh11Regs.f
PASSMSG  = Everything OK

.PHONY: simulate clean

# Build, run, and pass only if the pass message shows up
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "$(PASSMSG)"

clean:
	rm -rf obj_dir
